//--- bench/tri_isect_sva.sv
`default_nettype none

module tri_isect_sva (
  input logic               clk,
  input logic               rst,
  input logic               prev_done,
  input logic               capture,
  input tri_pkg::edge_set_t edges_in
);

  // Capture is a single-cycle pulse.
  capture_pulse: assert property (@(posedge clk) disable iff (rst)
    capture |=> !capture)
    else $error("capture was high for two cycles running");

  done_held: assert property (@(posedge clk) disable iff (rst)
    prev_done && !capture |=> prev_done)
    else $error("setup done dropped before capture");

  // The payload must not move while it waits to be loaded.
  edges_stable: assert property (@(posedge clk) disable iff (rst)
    prev_done && !capture |=> $stable(edges_in))
    else $error("setup edges changed while done was high");

endmodule

bind tri_stage_reg tri_isect_sva stage_sva_inst (
  .clk       (clk),
  .rst       (rst),
  .prev_done (prev_done),
  .capture   (capture),
  .edges_in  (edges_in)
);

`default_nettype wire

//--- bench/tri_isect_tb.sv
`default_nettype none

module tri_isect_tb;
  import tri_pkg::*;

  localparam int num_tests = 18;
  localparam int words_per_test = 27;
  localparam int half_period = 2;
  localparam int reset_cycles = 8;
  localparam int timeout_cycles = 40 * num_tests + 100;

  logic     clk;
  logic     rst;
  logic     start;
  ray_req_t req;
  logic     ready;
  logic     res_valid;
  hit_res_t res;

  logic [31:0] words [0:num_tests*words_per_test-1];
  ray_req_t    req_list [num_tests];
  hit_res_t    exp_list [num_tests];
  logic [31:0] lcg_state;
  int          starts_sent;
  int          checked;

  tri_isect_top tri_isect_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .req       (req),
    .ready     (ready),
    .res_valid (res_valid),
    .res       (res)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_field(input string name, input int idx,
                               input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      abort_run($sformatf("ERR %s in result %0d: got %h, expected %h", name, idx, got, want));
    end
  endtask

  // Each line of the file is one test of 27 words; see the file's opening comment.
  task automatic load_tests();
    int i;
    int b;
    $readmemh("bench/tri_isect_testdata.hex", words);
    for (i = 0; i < num_tests; i++) begin
      b = i * words_per_test;
      req_list[i].orig = {words[b], words[b+1], words[b+2]};
      req_list[i].dir  = {words[b+3], words[b+4], words[b+5]};
      req_list[i].v0   = {words[b+6], words[b+7], words[b+8]};
      req_list[i].v1   = {words[b+9], words[b+10], words[b+11]};
      req_list[i].v2   = {words[b+12], words[b+13], words[b+14]};
      req_list[i].tag.tri_id    = words[b+15][8:0];
      req_list[i].tag.thread_id = words[b+16][4:0];
      req_list[i].tag.sid       = words[b+17];
      exp_list[i].hit = words[b+18][0];
      exp_list[i].det = {words[b+19], words[b+20]};
      exp_list[i].u   = {words[b+21], words[b+22]};
      exp_list[i].v   = {words[b+23], words[b+24]};
      exp_list[i].t   = {words[b+25], words[b+26]};
      exp_list[i].tag = req_list[i].tag; // Tags pass through unchanged.
    end
  endtask

  task automatic check_result(input int idx, input hit_res_t got);
    hit_res_t want;
    want = exp_list[idx];
    compare_field("hit", idx, got.hit, want.hit);
    compare_field("det", idx, got.det, want.det);
    compare_field("u", idx, got.u, want.u);
    compare_field("v", idx, got.v, want.v);
    compare_field("t", idx, got.t, want.t);
    compare_field("tri_id", idx, got.tag.tri_id, want.tag.tri_id);
    compare_field("thread_id", idx, got.tag.thread_id, want.tag.thread_id);
    compare_field("sid", idx, got.tag.sid, want.tag.sid);
  endtask

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    int idx;
    logic [31:0] rnd;
    rst = 1'b1;
    start = 1'b0;
    req = '0;
    lcg_state = 32'h754c;
    starts_sent = 0;
    checked = 0;
    load_tests();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (ready === 1'b1) else abort_run("ready is not high after reset");
    for (idx = 0; idx < num_tests; idx++) begin
      rnd = next_rand();
      if (idx >= 4) begin
        repeat (rnd[17:16]) @(negedge clk); // The first four rays go back to back.
      end
      while (ready !== 1'b1) @(negedge clk);
      req = req_list[idx];
      start = 1'b1;
      starts_sent = starts_sent + 1;
      @(negedge clk);
      start = 1'b0;
    end
    wait (checked == num_tests);
    repeat (10) @(negedge clk); // A spurious extra result would show up in these cycles.
    $display("Result: PASSED");
    $finish;
  end

  // Results are sampled mid-cycle, where res_valid and res are stable.
  initial begin
    forever begin
      @(negedge clk);
      if (res_valid === 1'b1) begin
        assert (checked < starts_sent) else abort_run("a result arrived with no ray in flight");
        check_result(checked, res);
        checked = checked + 1;
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    abort_run($sformatf("Timeout: only %0d of %0d results arrived", checked, num_tests));
  end

endmodule

`default_nettype wire

//--- bench/tri_isect_testdata.hex
// orig xyz, dir xyz, v0 xyz, v1 xyz, v2 xyz, tri_id, thread_id, sid,
// then expected hit, det hi lo, u hi lo, v hi lo, t hi lo; one test per line
// Front-facing triangle, inside, on the corner and on the u+v edge.
2 3 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 1 0 1000 1 0 64 0 14 0 1e 0 1f4
0 0 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 2 1 1001 1 0 64 0 0 0 0 0 1f4
4 6 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 3 2 1002 1 0 64 0 28 0 3c 0 1f4
// Misses with positive det: u below 0, v below 0, u+v above det, t negative.
ffffffff 3 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 10 3 1003 0 0 64 ffffffff fffffff6 0 1e 0 1f4
3 ffffffff 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 20 4 1004 0 0 64 0 1e ffffffff fffffff6 0 1f4
5 6 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 40 5 1005 0 0 64 0 32 0 3c 0 1f4
2 3 fffffffb 0 0 ffffffff 0 0 0 a 0 0 0 a 0 80 6 1006 0 0 64 0 14 0 1e ffffffff fffffe0c
2 3 0 0 0 ffffffff 0 0 0 a 0 0 0 a 0 100 7 1007 1 0 64 0 14 0 1e 0 0
// Ray parallel to the plane.
2 3 5 1 0 0 0 0 0 a 0 0 0 a 0 0 8 1008 0 0 0 0 32 0 0 0 1f4
// Back-facing triangle with mirrored comparisons.
2 3 5 0 0 ffffffff 0 0 0 0 a 0 a 0 0 11 9 1009 1 ffffffff ffffff9c ffffffff ffffffe2 ffffffff ffffffec ffffffff fffffe0c
5 5 5 0 0 ffffffff 0 0 0 0 a 0 a 0 0 22 a 100a 1 ffffffff ffffff9c ffffffff ffffffce ffffffff ffffffce ffffffff fffffe0c
8 5 5 0 0 ffffffff 0 0 0 0 a 0 a 0 0 33 b 100b 0 ffffffff ffffff9c ffffffff ffffffce ffffffff ffffffb0 ffffffff fffffe0c
fffffffe 3 5 0 0 ffffffff 0 0 0 0 a 0 a 0 0 44 c 100c 0 ffffffff ffffff9c ffffffff ffffffe2 0 14 ffffffff fffffe0c
2 3 fffffffb 0 0 ffffffff 0 0 0 0 a 0 a 0 0 55 d 100d 0 ffffffff ffffff9c ffffffff ffffffe2 ffffffff ffffffec 0 1f4
// Cross products that wrap at 32 bits.
1 2 5 0 0 fffffffd 0 0 0 40000000 0 0 0 60000000 0 1fe 1e deadbeef 1 08000000 0 0 20000000 1 80000000 18000000 0
1 2 5 0 0 fffffffb 0 0 0 40000000 0 0 0 60000000 0 66 f 12345678 0 f8000000 0 ffffffff e0000000 2 80000000 18000000 0
// Small hit and a boundary hit with the largest tags.
1 1 2 0 0 ffffffff 0 0 0 a 0 0 0 a 0 77 10 100e 1 0 64 0 a 0 a 0 c8
9 1 5 0 0 ffffffff 0 0 0 a 0 0 0 a 0 1ff 1f ffffffff 1 0 64 0 5a 0 a 0 1f4

//--- design/cross_unit.sv
`default_nettype none

module cross_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  tri_pkg::vec3_t a,
  input  tri_pkg::vec3_t b,
  input  logic           take,
  output logic           done,
  output tri_pkg::vec3_t result
);
  import tri_pkg::*;

  typedef enum logic [1:0] {st_idle, st_y, st_z, st_hold} state_t;

  state_t state;
  vec3_t  a_q;
  vec3_t  b_q;
  vec3_t  op_a;
  vec3_t  op_b;
  comp_t  lhs;
  comp_t  rhs;
  comp_t  comp;

  // The x component is formed from the live inputs in the start cycle.
  assign op_a = (state == st_idle) ? a : a_q;
  assign op_b = (state == st_idle) ? b : b_q;

  always_comb begin
    case (state)
      st_y: begin
        lhs = op_a.z * op_b.x;
        rhs = op_a.x * op_b.z;
      end
      st_z: begin
        lhs = op_a.x * op_b.y;
        rhs = op_a.y * op_b.x;
      end
      default: begin
        lhs = op_a.y * op_b.z;
        rhs = op_a.z * op_b.y;
      end
    endcase
    comp = lhs - rhs; // Products and difference wrap at 32 bits.
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_y;
          end
        end
        st_y: begin
          state <= st_z;
        end
        st_z: begin
          state <= st_hold;
        end
        default: begin
          if (take) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      a_q <= a;
      b_q <= b;
      result.x <= comp;
    end else if (state == st_y) begin
      result.y <= comp;
    end else if (state == st_z) begin
      result.z <= comp;
    end
  end

  assign done = (state == st_hold); // High three cycles after start.

endmodule

`default_nettype wire

//--- design/hit_test.sv
`default_nettype none

module hit_test (
  input  logic               clk,
  input  logic               rst,
  input  logic               pvec_done,
  input  logic               qvec_done,
  input  tri_pkg::vec3_t     pvec,
  input  tri_pkg::vec3_t     qvec,
  input  tri_pkg::edge_set_t edges,
  output logic               take,
  output logic               free,
  output logic               res_valid,
  output tri_pkg::hit_res_t  res
);
  import tri_pkg::*;

  logic               boot_q;
  logic               s1_valid;
  wide_t              s1_det;
  wide_t              s1_u;
  wide_t              s1_v;
  wide_t              s1_t;
  tag_t               s1_tag;
  logic signed [64:0] uv_sum;
  logic               hit;

  // Exact products, summed in 64 bits.
  function automatic wide_t dot3(input vec3_t a, input vec3_t b);
    wide_t acc;
    acc = wide_t'(a.x) * wide_t'(b.x);
    acc = acc + wide_t'(a.y) * wide_t'(b.y);
    acc = acc + wide_t'(a.z) * wide_t'(b.z);
    return acc;
  endfunction

  // The result port never stalls, so both stages always advance.
  assign take = pvec_done && qvec_done;
  assign free = take || boot_q; // The cross pair is empty once its results are taken.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      boot_q <= 1'b1;
      s1_valid <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      s1_valid <= take;
      res_valid <= s1_valid;
    end
  end

  // Edges stay valid until the next load, which is at the earliest at the end of this cycle.
  always_ff @(posedge clk) begin
    if (take) begin
      s1_det <= dot3(edges.v0v1, pvec);
      s1_u   <= dot3(edges.tvec, pvec);
      s1_v   <= dot3(edges.dir, qvec);
      s1_t   <= dot3(edges.v0v2, qvec);
      s1_tag <= edges.tag;
    end
  end

  always_comb begin
    uv_sum = s1_u + s1_v; // One extra bit keeps the sum exact.
    if (s1_det > 0) begin
      hit = (s1_u >= 0) && (s1_v >= 0) && (uv_sum <= s1_det) && (s1_t >= 0);
    end else if (s1_det < 0) begin
      hit = (s1_u <= 0) && (s1_v <= 0) && (uv_sum >= s1_det) && (s1_t <= 0);
    end else begin
      hit = 1'b0; // Ray parallel to the triangle plane.
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res.hit <= hit;
      res.det <= s1_det;
      res.u   <= s1_u;
      res.v   <= s1_v;
      res.t   <= s1_t;
      res.tag <= s1_tag;
    end
  end

endmodule

`default_nettype wire

//--- design/ray_setup.sv
`default_nettype none

module ray_setup (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  tri_pkg::ray_req_t  req,
  input  logic               capture,
  output logic               ready,
  output logic               done,
  output tri_pkg::edge_set_t edges
);
  import tri_pkg::*;

  typedef enum logic {st_idle, st_hold} state_t;

  state_t state;
  logic   accept;

  // Componentwise difference, wrapping at 32 bits.
  function automatic vec3_t vsub(input vec3_t a, input vec3_t b);
    vec3_t d;
    d.x = a.x - b.x;
    d.y = a.y - b.y;
    d.z = a.z - b.z;
    return d;
  endfunction

  assign ready = (state == st_idle);
  assign done = (state == st_hold);
  assign accept = start && ready; // Start is ignored while an item is held.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_hold;
          end
        end
        st_hold: begin
          if (capture) begin
            state <= st_idle; // Done drops in the cycle after capture.
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      edges.v0v1 <= vsub(req.v1, req.v0);
      edges.v0v2 <= vsub(req.v2, req.v0);
      edges.tvec <= vsub(req.orig, req.v0);
      edges.dir  <= req.dir;
      edges.tag  <= req.tag;
    end
  end

endmodule

`default_nettype wire

//--- design/tri_isect_top.sv
`default_nettype none

module tri_isect_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  tri_pkg::ray_req_t req,
  output logic              ready,
  output logic              res_valid,
  output tri_pkg::hit_res_t res
);
  import tri_pkg::*;

  logic      setup_done;
  edge_set_t setup_edges;
  logic      stage_capture;
  edge_set_t stage_edges;
  logic      pvec_done;
  logic      qvec_done;
  vec3_t     pvec;
  vec3_t     qvec;
  logic      cross_take;
  logic      cross_free;

  ray_setup setup_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .req     (req),
    .capture (stage_capture),
    .ready   (ready),
    .done    (setup_done),
    .edges   (setup_edges)
  );

  tri_stage_reg stage_inst (
    .clk       (clk),
    .rst       (rst),
    .prev_done (setup_done),
    .next_free (cross_free),
    .edges_in  (setup_edges),
    .capture   (stage_capture),
    .edges_out (stage_edges)
  );

  // Both units start on the same capture pulse and finish together.
  cross_unit pvec_unit (
    .clk    (clk),
    .rst    (rst),
    .start  (stage_capture),
    .a      (stage_edges.dir),
    .b      (stage_edges.v0v2),
    .take   (cross_take),
    .done   (pvec_done),
    .result (pvec)
  );

  cross_unit qvec_unit (
    .clk    (clk),
    .rst    (rst),
    .start  (stage_capture),
    .a      (stage_edges.tvec),
    .b      (stage_edges.v0v1),
    .take   (cross_take),
    .done   (qvec_done),
    .result (qvec)
  );

  hit_test hit_inst (
    .clk       (clk),
    .rst       (rst),
    .pvec_done (pvec_done),
    .qvec_done (qvec_done),
    .pvec      (pvec),
    .qvec      (qvec),
    .edges     (stage_edges),
    .take      (cross_take),
    .free      (cross_free),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

`default_nettype wire

//--- design/tri_pkg.sv
`default_nettype none

package tri_pkg;

  localparam int num_triangle = 512;
  localparam int num_thread = 32;

  // Plain vector types.
  typedef logic signed [31:0] comp_t;
  typedef logic signed [63:0] wide_t;
  typedef logic [$clog2(num_triangle)-1:0] tri_id_t;
  typedef logic [$clog2(num_thread)-1:0] thread_id_t;
  typedef logic [31:0] sid_t;

  typedef struct packed {
    comp_t x; // Most significant component.
    comp_t y;
    comp_t z;
  } vec3_t;

  typedef struct packed {
    tri_id_t    tri_id;
    thread_id_t thread_id;
    sid_t       sid;
  } tag_t;

  // One ray against one triangle, as it enters the pipeline.
  typedef struct packed {
    vec3_t orig;
    vec3_t dir;
    vec3_t v0;
    vec3_t v1;
    vec3_t v2;
    tag_t  tag;
  } ray_req_t;

  typedef struct packed {
    vec3_t v0v1;
    vec3_t v0v2;
    vec3_t dir;
    vec3_t tvec; // Ray origin relative to v0.
    tag_t  tag;
  } edge_set_t;

  typedef struct packed {
    logic  hit;
    wide_t det;
    wide_t u;
    wide_t v;
    wide_t t;
    tag_t  tag;
  } hit_res_t;

endpackage

`default_nettype wire

//--- design/tri_stage_reg.sv
`default_nettype none

module tri_stage_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               prev_done,
  input  logic               next_free,
  input  tri_pkg::edge_set_t edges_in,
  output logic               capture,
  output tri_pkg::edge_set_t edges_out
);
  import tri_pkg::*;

  // Done and free may arrive in either order; the register loads once it has both.
  typedef enum logic [1:0] {
    st_idle,
    st_done_seen,
    st_free_seen,
    st_load
  } state_t;

  state_t    state;
  state_t    nxt_state;
  logic      ld;
  edge_set_t edges_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    ld = 1'b0;
    nxt_state = state;
    case (state)
      st_idle: begin
        if (prev_done && next_free) begin
          ld = 1'b1;
          nxt_state = st_load;
        end else if (prev_done) begin
          nxt_state = st_done_seen;
        end else if (next_free) begin
          nxt_state = st_free_seen;
        end
      end
      st_done_seen: begin
        if (next_free) begin
          ld = 1'b1;
          nxt_state = st_load;
        end
      end
      st_free_seen: begin
        if (prev_done) begin
          ld = 1'b1;
          nxt_state = st_load;
        end
      end
      default: begin
        nxt_state = st_idle; // One capture cycle, then back to waiting.
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (ld) begin
      edges_q <= edges_in;
    end
  end

  assign capture = (state == st_load); // Releases setup and starts both cross units.
  assign edges_out = edges_q;

endmodule

`default_nettype wire

//--- sim.f
design/tri_pkg.sv
design/ray_setup.sv
design/tri_stage_reg.sv
design/cross_unit.sv
design/hit_test.sv
design/tri_isect_top.sv
bench/tri_isect_sva.sv
bench/tri_isect_tb.sv
